//--- hdl/seg_game_pkg.sv
package seg_game_pkg;

    // Game controller states
    typedef enum logic [1:0] {
        ST_INITIAL,
        ST_MOVING,
        ST_FALLING
    } game_state_e;

    // Direction the cursor travels along its segment
    typedef enum logic [1:0] {
        HEAD_RIGHT,
        HEAD_LEFT,
        HEAD_UP,
        HEAD_DOWN
    } heading_e;

    // Segment index doubles as bit position in a pattern
    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_idx_e;

    // Active low, bit i drives segment i
    typedef logic [6:0] seg_pattern_t;

    // Active low digit enables
    typedef logic [3:0] digit_sel_t;

    localparam int DEBOUNCE_LEN    = 4;
    localparam int SECOND_CYCLES   = 64;
    localparam int HALF_CYCLES     = 32;
    localparam int INITIAL_SECONDS = 3;
    localparam int SCAN_CYCLES     = 4;

    localparam seg_pattern_t SEG_BLANK   = 7'b1111111;
    localparam seg_pattern_t SEG_ALL_LIT = 7'b0000000;
    localparam seg_idx_e     START_SEG   = SEG_G;
    localparam heading_e     START_HEAD  = HEAD_LEFT;
    localparam digit_sel_t   SHOW_DIGIT  = 4'b1110;
    localparam digit_sel_t   DIGIT_OFF   = 4'b1111;

endpackage

//--- hdl/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic press
);
    import seg_game_pkg::*;

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    level;
    logic                    level_d;

    // Pressed only once every recent sample is high
    assign level = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
        end else begin
            samples <= {samples[DEBOUNCE_LEN-2:0], btn};
        end
    end

    // One pulse on the rising edge of the debounced level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level_d <= 1'b0;
            press   <= 1'b0;
        end else begin
            level_d <= level;
            press   <= level & ~level_d;
        end
    end

endmodule

//--- hdl/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int PERIOD = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic tick
);
    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CNT_W-1:0] count;

    assign tick = en && (count == CNT_W'(PERIOD - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (!en) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- hdl/segment_walker.sv
`timescale 1ns/1ps

module segment_walker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  walk_load,
    input  logic                  walk_en,
    input  logic                  press_right,
    input  logic                  press_left,
    input  logic                  press_up,
    output seg_game_pkg::seg_idx_e cursor,
    output seg_game_pkg::heading_e heading
);
    import seg_game_pkg::*;

    seg_idx_e nxt_cursor;
    heading_e nxt_heading;

    // Move table, entries tried right first, then left, then up
    always_comb begin
        nxt_cursor  = cursor;
        nxt_heading = heading;
        case (cursor)
            SEG_A: begin
                if (heading == HEAD_RIGHT && press_right) begin
                    nxt_cursor  = SEG_B;
                    nxt_heading = HEAD_DOWN;
                end else if (heading == HEAD_LEFT && press_left) begin
                    nxt_cursor  = SEG_F;
                    nxt_heading = HEAD_DOWN;
                end
            end
            SEG_B: begin
                if (heading == HEAD_DOWN && press_right) begin
                    nxt_cursor  = SEG_G;
                    nxt_heading = HEAD_LEFT;
                end else if (heading == HEAD_UP && press_left) begin
                    nxt_cursor  = SEG_A;
                    nxt_heading = HEAD_LEFT;
                end else if (heading == HEAD_DOWN && press_up) begin
                    nxt_cursor  = SEG_C;
                    nxt_heading = HEAD_DOWN;
                end
            end
            SEG_C: begin
                if (heading == HEAD_DOWN && press_right) begin
                    nxt_cursor  = SEG_D;
                    nxt_heading = HEAD_DOWN;
                end else if (heading == HEAD_UP && press_left) begin
                    nxt_cursor  = SEG_G;
                    nxt_heading = HEAD_LEFT;
                end else if (heading == HEAD_UP && press_up) begin
                    nxt_cursor  = SEG_B;
                    nxt_heading = HEAD_UP;
                end
            end
            SEG_D: begin
                if (heading == HEAD_LEFT && press_right) begin
                    nxt_cursor  = SEG_E;
                    nxt_heading = HEAD_UP;
                end else if (heading == HEAD_RIGHT && press_left) begin
                    nxt_cursor  = SEG_C;
                    nxt_heading = HEAD_UP;
                end
            end
            SEG_E: begin
                if (heading == HEAD_UP && press_right) begin
                    nxt_cursor  = SEG_G;
                    nxt_heading = HEAD_RIGHT;
                end else if (heading == HEAD_DOWN && press_left) begin
                    nxt_cursor  = SEG_D;
                    nxt_heading = HEAD_RIGHT;
                end else if (heading == HEAD_UP && press_up) begin
                    nxt_cursor  = SEG_F;
                    nxt_heading = HEAD_UP;
                end
            end
            SEG_F: begin
                if (heading == HEAD_UP && press_right) begin
                    nxt_cursor  = SEG_A;
                    nxt_heading = HEAD_RIGHT;
                end else if (heading == HEAD_DOWN && press_left) begin
                    nxt_cursor  = SEG_G;
                    nxt_heading = HEAD_RIGHT;
                end
            end
            SEG_G: begin
                if (heading == HEAD_RIGHT && press_right) begin
                    nxt_cursor  = SEG_C;
                    nxt_heading = HEAD_DOWN;
                end else if (heading == HEAD_LEFT && press_right) begin
                    nxt_cursor  = SEG_F;
                    nxt_heading = HEAD_UP;
                end else if (heading == HEAD_RIGHT && press_left) begin
                    nxt_cursor  = SEG_B;
                    nxt_heading = HEAD_UP;
                end else if (heading == HEAD_LEFT && press_left) begin
                    nxt_cursor  = SEG_E;
                    nxt_heading = HEAD_DOWN;
                end
            end
            default: begin
                nxt_cursor  = START_SEG;
                nxt_heading = START_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cursor  <= START_SEG;
            heading <= START_HEAD;
        end else if (walk_load) begin
            cursor  <= START_SEG;
            heading <= START_HEAD;
        end else if (walk_en) begin
            cursor  <= nxt_cursor;
            heading <= nxt_heading;
        end
    end

endmodule

//--- hdl/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      press_down,
    input  logic                      sec_tick,
    input  logic                      half_tick,
    input  seg_game_pkg::seg_idx_e     cursor,
    output logic                      sec_en,
    output logic                      half_en,
    output logic                      walk_load,
    output logic                      walk_en,
    output seg_game_pkg::seg_pattern_t pattern
);
    import seg_game_pkg::*;

    localparam int SEC_W = $clog2(INITIAL_SECONDS + 1);

    game_state_e      state;
    logic [SEC_W-1:0] sec_cnt;
    seg_pattern_t     record;
    logic             flash_on;

    // Second ticks only count while waiting in initial
    assign sec_en    = (state == ST_INITIAL);
    assign half_en   = (state == ST_FALLING);
    assign walk_load = (state == ST_INITIAL);
    assign walk_en   = (state != ST_INITIAL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_INITIAL;
            sec_cnt  <= '0;
            record   <= SEG_BLANK;
            flash_on <= 1'b0;
        end else begin
            case (state)
                ST_INITIAL: begin
                    if (sec_tick) begin
                        if (sec_cnt == SEC_W'(INITIAL_SECONDS - 1)) begin
                            sec_cnt <= '0;
                            state   <= ST_MOVING;
                        end else begin
                            sec_cnt <= sec_cnt + 1'b1;
                        end
                    end
                end
                ST_MOVING: begin
                    if (press_down) begin
                        state    <= ST_FALLING;
                        record   <= SEG_ALL_LIT;
                        flash_on <= 1'b1;
                    end
                end
                ST_FALLING: begin
                    // Trail goes dark wherever the cursor has been
                    record[cursor] <= 1'b1;
                    if (half_tick) begin
                        flash_on <= ~flash_on;
                        if (record == SEG_BLANK) begin
                            state    <= ST_INITIAL;
                            flash_on <= 1'b0;
                        end
                    end
                end
                default: begin
                    state <= ST_INITIAL;
                end
            endcase
        end
    end

    // Single lit cursor, or the trail with a blinking cursor
    always_comb begin
        pattern = SEG_BLANK;
        if (state == ST_FALLING) begin
            pattern         = record;
            pattern[cursor] = ~flash_on;
        end else begin
            pattern[cursor] = 1'b0;
        end
    end

endmodule

//--- hdl/display_scan.sv
`timescale 1ns/1ps

module display_scan (
    input  logic                      clk,
    input  logic                      rst,
    input  seg_game_pkg::seg_pattern_t pattern,
    output seg_game_pkg::digit_sel_t   digit,
    output seg_game_pkg::seg_pattern_t display
);
    import seg_game_pkg::*;

    localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

    logic [SCAN_W-1:0] scan_cnt;
    logic              step;
    digit_sel_t        nxt_digit;

    assign step = (scan_cnt == SCAN_W'(SCAN_CYCLES - 1));

    // Walk the low bit across the four digits
    always_comb begin
        nxt_digit = digit;
        if (step) begin
            case (digit)
                4'b1110: nxt_digit = 4'b1101;
                4'b1101: nxt_digit = 4'b1011;
                4'b1011: nxt_digit = 4'b0111;
                default: nxt_digit = 4'b1110;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            digit    <= DIGIT_OFF;
            display  <= SEG_BLANK;
        end else begin
            scan_cnt <= step ? '0 : scan_cnt + 1'b1;
            digit    <= nxt_digit;
            // Only the rightmost digit carries the game
            display  <= (nxt_digit == SHOW_DIGIT) ? pattern : SEG_BLANK;
        end
    end

endmodule

//--- hdl/seg_game_top.sv
`timescale 1ns/1ps

module seg_game_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      btn_right,
    input  logic                      btn_left,
    input  logic                      btn_up,
    input  logic                      btn_down,
    output seg_game_pkg::digit_sel_t   digit,
    output seg_game_pkg::seg_pattern_t display
);
    import seg_game_pkg::*;

    logic         press_right;
    logic         press_left;
    logic         press_up;
    logic         press_down;
    logic         sec_en;
    logic         sec_tick;
    logic         half_en;
    logic         half_tick;
    logic         walk_load;
    logic         walk_en;
    seg_idx_e     cursor;
    seg_pattern_t pattern;

    button_conditioner u_btn_right (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_right),
        .press (press_right)
    );

    button_conditioner u_btn_left (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_left),
        .press (press_left)
    );

    button_conditioner u_btn_up (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_up),
        .press (press_up)
    );

    button_conditioner u_btn_down (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_down),
        .press (press_down)
    );

    tick_gen #(.PERIOD(SECOND_CYCLES)) u_sec_tick (
        .clk  (clk),
        .rst  (rst),
        .en   (sec_en),
        .tick (sec_tick)
    );

    tick_gen #(.PERIOD(HALF_CYCLES)) u_half_tick (
        .clk  (clk),
        .rst  (rst),
        .en   (half_en),
        .tick (half_tick)
    );

    segment_walker u_walker (
        .clk         (clk),
        .rst         (rst),
        .walk_load   (walk_load),
        .walk_en     (walk_en),
        .press_right (press_right),
        .press_left  (press_left),
        .press_up    (press_up),
        .cursor      (cursor),
        .heading     ()
    );

    game_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .press_down (press_down),
        .sec_tick   (sec_tick),
        .half_tick  (half_tick),
        .cursor     (cursor),
        .sec_en     (sec_en),
        .half_en    (half_en),
        .walk_load  (walk_load),
        .walk_en    (walk_en),
        .pattern    (pattern)
    );

    display_scan u_scan (
        .clk     (clk),
        .rst     (rst),
        .pattern (pattern),
        .digit   (digit),
        .display (display)
    );

endmodule

//--- verif/seg_game_assert.sv
`timescale 1ns/1ps

module seg_game_assert (
    input logic                      clk,
    input logic                      rst,
    input logic                      walk_en,
    input logic                      half_en,
    input seg_game_pkg::digit_sel_t   digit,
    input seg_game_pkg::seg_pattern_t display
);
    import seg_game_pkg::*;

    int fail_count;

    initial begin
        fail_count = 0;
    end

    // Idle code or one of the four scan positions
    digit_legal: assert property (@(posedge clk) disable iff (rst)
        digit inside {4'b1111, 4'b1110, 4'b1101, 4'b1011, 4'b0111})
    else begin
        $error("digit enable %b is not a legal scan code", digit);
        fail_count++;
    end

    blank_off_digit: assert property (@(posedge clk) disable iff (rst)
        (digit != SHOW_DIGIT) |-> (display == SEG_BLANK))
    else begin
        $error("display %b is not blank while digit is %b", display, digit);
        fail_count++;
    end

    // Moving state is walking without the half-second timer
    single_segment_moving: assert property (@(posedge clk) disable iff (rst)
        (walk_en && !half_en && digit == SHOW_DIGIT) |-> ($countones(~display) == 1))
    else begin
        $error("display %b lights more or less than one segment while moving", display);
        fail_count++;
    end

endmodule

bind seg_game_top seg_game_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .walk_en (walk_en),
    .half_en (half_en),
    .digit   (digit),
    .display (display)
);

//--- verif/seg_game_tb.sv
`timescale 1ns/1ps

module seg_game_tb;
    import seg_game_pkg::*;

    localparam int HOLD_CYCLES     = 8;
    localparam int RELEASE_CYCLES  = 8;
    localparam int GLITCH_CYCLES   = 2;
    localparam int PATTERN_TIMEOUT = 64;
    localparam int RETURN_TIMEOUT  = 4 * HALF_CYCLES + 64;
    localparam int INITIAL_WAIT    = INITIAL_SECONDS * SECOND_CYCLES + 8;

    logic         clk;
    logic         rst;
    logic         btn_right;
    logic         btn_left;
    logic         btn_up;
    logic         btn_down;
    digit_sel_t   digit;
    seg_pattern_t display;

    // Segment, heading, button, new segment, new heading
    string move_table [19] = '{
        "ARrBD", "ALlFD",
        "BUlAL", "BDrGL", "BDuCD",
        "CUlGL", "CUuBU", "CDrDD",
        "DRlCU", "DLrEU",
        "EUrGR", "EUuFU", "EDlDR",
        "FUrAR", "FDlGR",
        "GRlBU", "GRrCD", "GLlED", "GLrFU"
    };

    game_state_e  model_state;
    byte          model_seg;
    byte          model_head;
    seg_pattern_t model_record;
    int           check_count;
    int           mismatch_count;
    int           other_errors;

    seg_game_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .btn_right (btn_right),
        .btn_left  (btn_left),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .digit     (digit),
        .display   (display)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One bit set at the segment's position
    function automatic seg_pattern_t seg_bit(input byte seg);
        seg_pattern_t bits;
        int           idx;
        bits = '0;
        idx = seg - 8'h41;
        bits[idx] = 1'b1;
        return bits;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            mismatch_count++;
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic set_button(input string btn, input logic level);
        case (btn)
            "right": btn_right <= level;
            "left":  btn_left  <= level;
            "up":    btn_up    <= level;
            "down":  btn_down  <= level;
            default: begin
                other_errors++;
                $display("ERROR unknown button name %s in case file", btn);
            end
        endcase
    endtask

    task automatic press_button(input string btn, input int hold);
        @(posedge clk);
        set_button(btn, 1'b1);
        repeat (hold) @(posedge clk);
        set_button(btn, 1'b0);
        repeat (RELEASE_CYCLES) @(posedge clk);
    endtask

    // Walk the table, only the first matching entry applies
    task automatic step_model(input string btn);
        byte key;
        bit  done;
        key = btn[0];
        done = 1'b0;
        if (model_state != ST_INITIAL) begin
            foreach (move_table[i]) begin
                if (!done && move_table[i][0] == model_seg && move_table[i][1] == model_head
                        && move_table[i][2] == key) begin
                    model_seg  = move_table[i][3];
                    model_head = move_table[i][4];
                    done = 1'b1;
                    if (model_state == ST_FALLING) begin
                        model_record = model_record | seg_bit(model_seg);
                    end
                end
            end
        end
    endtask

    // Poll the rightmost digit until the masked pattern shows up
    task automatic expect_display(input string name, input seg_pattern_t expected,
                                  input seg_pattern_t mask);
        seg_pattern_t seen;
        int           waited;
        bit           matched;
        bit           saw_digit;
        seen = SEG_BLANK | mask;
        waited = 0;
        matched = 1'b0;
        saw_digit = 1'b0;
        while (!matched && waited < PATTERN_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (digit == SHOW_DIGIT) begin
                saw_digit = 1'b1;
                seen = display | mask;
                matched = (seen == (expected | mask));
            end
        end
        if (!saw_digit) begin
            other_errors++;
            $display("ERROR %s: rightmost digit was never enabled", name);
        end
        check_value(name, expected | mask, seen);
    endtask

    task automatic wait_for_restart(input string name);
        int waited;
        bit seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < RETURN_TIMEOUT) begin
            @(negedge clk);
            waited++;
            seen = (digit == SHOW_DIGIT) && (display == ~seg_bit("G"));
        end
        if (!seen) begin
            other_errors++;
            $display("ERROR %s: game did not come back to segment G alone in time", name);
        end
    endtask

    task automatic run_case(input string name, input string action, input byte exp_seg);
        if (action == "wait_initial") begin
            wait_for_restart(name);
            repeat (INITIAL_WAIT) @(posedge clk);
            model_state  = ST_MOVING;
            model_seg    = "G";
            model_head   = "L";
            model_record = SEG_BLANK;
        end else if (action.substr(0, 6) == "glitch_") begin
            press_button(action.substr(7, action.len() - 1), GLITCH_CYCLES);
        end else if (action == "down") begin
            press_button(action, HOLD_CYCLES);
            if (model_state == ST_MOVING) begin
                model_state  = ST_FALLING;
                model_record = seg_bit(model_seg);
            end
        end else begin
            press_button(action, HOLD_CYCLES);
            step_model(action);
        end
        check_value({name, " cursor"}, exp_seg, model_seg);
        // An empty record may already be on its way back to initial
        if (model_state == ST_FALLING && model_record != SEG_BLANK) begin
            expect_display(name, model_record, seg_bit(model_seg));
        end else if (model_state != ST_FALLING) begin
            expect_display(name, ~seg_bit(model_seg), '0);
        end
    endtask

    initial begin
        string line;
        string name;
        string action;
        string letter;
        int    fd;
        int    got;
        int    assert_fails;
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;
        model_state    = ST_INITIAL;
        model_seg      = "G";
        model_head     = "L";
        model_record   = SEG_BLANK;
        rst       <= 1'b1;
        btn_right <= 1'b0;
        btn_left  <= 1'b0;
        btn_up    <= 1'b0;
        btn_down  <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset_digit", DIGIT_OFF, digit);
        check_value("reset_display", SEG_BLANK, display);
        expect_display("reset_start", ~seg_bit("G"), '0);

        fd = $fopen("verif/seg_game_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR cannot open verif/seg_game_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got = $fgets(line, fd);
                if (got > 0 && line[0] != "#") begin
                    got = $sscanf(line, "%s %s %s", name, action, letter);
                    if (got == 3) begin
                        run_case(name, action, letter[0]);
                    end
                end
            end
            $fclose(fd);
        end

        assert_fails = u_dut.u_assert.fail_count;
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 check_count, mismatch_count, other_errors, assert_fails);
        if (check_count > 0 && mismatch_count == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/seg_game_pkg.sv
hdl/button_conditioner.sv
hdl/tick_gen.sv
hdl/segment_walker.sv
hdl/game_ctrl.sv
hdl/display_scan.sv
hdl/seg_game_top.sv
verif/seg_game_assert.sv
verif/seg_game_tb.sv

//--- verif/seg_game_cases.txt
# columns: case name, action (right/left/up/down, glitch_<button>, wait_initial),
# expected cursor segment letter after the action
init_press       right          G
init_wait        wait_initial   G
loop_g_f         right          F
f_up_ignored     up             F
loop_f_a         right          A
loop_a_b         right          B
loop_b_g         right          G
g_up_ignored     up             G
g_glitch         glitch_right   G
loop_g_e         left           E
e_right_ignored  right          E
loop_e_d         left           D
d_right_ignored  right          D
loop_d_c         left           C
loop_c_g         left           G
fall_enter       down           G
fall_g_e         left           E
fall_e_ignored   right          E
fall_e_d         left           D
fall_d_c         left           C
fall_c_b         up             B
fall_b_a         left           A
fall_a_f         left           F
restart_wait     wait_initial   G
again_g_f        right          F
again_f_a        right          A
